// ==== sim.f ====
src/capture_pkg.sv
src/fifo_status_if.sv
src/adc_sample_packer.sv
src/capture_control.sv
src/sample_fifo.sv
src/usb_byte_reader.sv
src/adc_capture_top.sv
test/tb_adc_capture.sv

// ==== Makefile ====
TOP = tb_adc_capture

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -f sim.f --top-module $(TOP) -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "^Test passed$$"

clean:
	rm -rf obj_dir

// ==== test/tb_adc_capture.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_adc_capture import capture_pkg::*; ();

    localparam int FIFO_DEPTH = 16;
    localparam int MAX_CYCLES = 4000;              // Longest runs are a few hundred cycles each
    localparam int WAIT_LIMIT = 100;               // Cycles allowed per wait

    logic                adc_sampleclk;
    logic                fifo_rst;
    logic                arm;
    logic                capture_go;
    logic                stream_mode;
    logic [SAMPLE_W-1:0] adc_data;
    logic [DS_W-1:0]     downsample;
    logic [CNT_W-1:0]    presample_words;
    logic [CNT_W-1:0]    max_samples;
    logic                read_en;
    logic                capture_stop;
    logic                fifo_overflow;
    logic                read_empty;
    logic [7:0]          read_data;
    logic [CNT_W-1:0]    fifo_words;

    logic [SAMPLE_W-1:0] kept_q[$];                // Samples the packer should keep
    logic [WORD_W-1:0]   exp_q[$];                 // Expected words in write order
    int                  errors = 0;
    int                  tests_run = 0;
    int                  tests_failed = 0;
    int                  cycle_cnt = 0;
    int unsigned         seed_init;

    adc_capture_top #(.FIFO_DEPTH(FIFO_DEPTH)) DUT (
        .adc_sampleclk     (adc_sampleclk),
        .fifo_rst          (fifo_rst),
        .arm_i             (arm),
        .capture_go_i      (capture_go),
        .stream_mode_i     (stream_mode),
        .adc_data_i        (adc_data),
        .downsample_i      (downsample),
        .presample_words_i (presample_words),
        .max_samples_i     (max_samples),
        .read_en_i         (read_en),
        .capture_stop_o    (capture_stop),
        .fifo_overflow_o   (fifo_overflow),
        .fifo_read_empty_o (read_empty),
        .fifo_read_data_o  (read_data),
        .fifo_words_o      (fifo_words)
    );

    initial begin
        adc_sampleclk = 1'b0;
        forever #20 adc_sampleclk = ~adc_sampleclk;    // 40 ns period
    end

    // Run limit
    always @(posedge adc_sampleclk) begin
        cycle_cnt++;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("Run stopped after %0d cycles, a test never finished", cycle_cnt);
            $display("Test failed");
            $finish;
        end
    end

    task automatic next_cycle();
        @(posedge adc_sampleclk);
        #5;                                        // Drive point
    endtask

    task automatic report_value(input string sig, input logic [31:0] exp_val,
                                input logic [31:0] act_val);
        $display("[FAIL] t=%0d ns %s expected 0x%0h actual 0x%0h", $time, sig, exp_val, act_val);
        errors++;
    endtask

    task automatic report_error(input string msg);
        $display("[FAIL] t=%0d ns %s", $time, msg);
        errors++;
    endtask

    task automatic end_test(input string name, input int err_start);
        tests_run++;
        if (errors == err_start) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d error(s)", name, errors - err_start);
            tests_failed++;
        end
    endtask

    // Tag on top, then slot 2, slot 1, slot 0
    function automatic logic [WORD_W-1:0] pack_word(input logic [1:0] tag,
                                                   input logic [SAMPLE_W-1:0] s0,
                                                   input logic [SAMPLE_W-1:0] s1,
                                                   input logic [SAMPLE_W-1:0] s2);
        return {tag, s2, s1, s0};
    endfunction

    task automatic pack_kept(input logic [1:0] tag);
        logic [SAMPLE_W-1:0] s0;
        logic [SAMPLE_W-1:0] s1;
        logic [SAMPLE_W-1:0] s2;
        while (kept_q.size() >= 3) begin
            s0 = kept_q.pop_front();
            s1 = kept_q.pop_front();
            s2 = kept_q.pop_front();
            exp_q.push_back(pack_word(tag, s0, s1, s2));
        end
    endtask

    // One sample per cycle and every (ds+1)-th one kept
    task automatic drive_samples(input int n, input int ds);
        for (int i = 0; i < n; i++) begin
            adc_data = SAMPLE_W'($urandom());
            if ((i % (ds + 1)) == ds) begin
                kept_q.push_back(adc_data);
            end
            next_cycle();
        end
    endtask

    task automatic arm_capture();
        arm = 1'b1;
        repeat (3) next_cycle();                   // Two sync flops, then flush edge
        arm = 1'b0;
        kept_q.delete();
        exp_q.delete();
    endtask

    task automatic wait_words(input int n);
        int waited;
        waited = 0;
        while ((fifo_words != CNT_W'(n)) && (waited < WAIT_LIMIT)) begin
            next_cycle();
            waited++;
        end
        if (fifo_words != CNT_W'(n)) begin
            report_value("fifo_words_o", 32'(n), fifo_words);
        end
    endtask

    task automatic wait_stop();
        int waited;
        waited = 0;
        while ((capture_stop !== 1'b1) && (waited < WAIT_LIMIT)) begin
            next_cycle();
            waited++;
        end
        if (capture_stop !== 1'b1) begin
            report_error("capture_stop_o did not rise in time");
        end
    endtask

    // Four byte reads per expected word with the low byte first
    task automatic read_words();
        logic [WORD_W-1:0] head;
        while (exp_q.size() > 0) begin
            head = exp_q.pop_front();
            for (int b = 0; b < BYTES_PER_WORD; b++) begin
                read_en = 1'b1;
                #1;                                // Byte mux settled
                if (read_empty !== 1'b0) begin
                    report_error("fifo_read_empty_o high while a word was expected");
                end
                if (read_data !== head[8*b +: 8]) begin
                    report_value("fifo_read_data_o", 32'(head[8*b +: 8]), 32'(read_data));
                end
                next_cycle();
            end
        end
        read_en = 1'b0;
    endtask

    task automatic after_reset_values();
        int err_start;
        err_start = errors;
        if (read_empty !== 1'b1) begin
            report_value("fifo_read_empty_o", 32'd1, 32'(read_empty));
        end
        if (capture_stop !== 1'b0) begin
            report_value("capture_stop_o", 32'd0, 32'(capture_stop));
        end
        if (fifo_overflow !== 1'b0) begin
            report_value("fifo_overflow_o", 32'd0, 32'(fifo_overflow));
        end
        end_test("after reset", err_start);
    endtask

    task automatic stream_capture(input string name, input int ds, input int n_samples);
        int err_start;
        err_start = errors;
        stream_mode = 1'b1;
        downsample  = DS_W'(ds);
        capture_go  = 1'b0;
        arm_capture();
        capture_go = 1'b1;
        drive_samples(n_samples, ds);
        capture_go = 1'b0;
        pack_kept(2'd0);                           // Trigger at slot 0
        wait_words(exp_q.size());
        read_words();
        if (read_empty !== 1'b1) begin
            report_value("fifo_read_empty_o", 32'd1, 32'(read_empty));
        end
        end_test(name, err_start);
    endtask

    task automatic normal_pretrigger();
        int err_start;
        err_start = errors;
        stream_mode     = 1'b0;
        downsample      = '0;
        capture_go      = 1'b0;
        presample_words = CNT_W'(3);
        max_samples     = CNT_W'(6);
        arm_capture();
        drive_samples(24, 0);                      // Eight words of history
        pack_kept(SLOT_NONE);
        while (exp_q.size() > int'(presample_words)) begin
            exp_q.delete(0);                       // Oldest dropped
        end
        capture_go = 1'b1;                         // Next sample lands in slot 0
        drive_samples(int'(max_samples), 0);
        pack_kept(2'd0);
        wait_stop();
        capture_go = 1'b0;
        if (fifo_words !== CNT_W'(5)) begin
            report_value("fifo_words_o", 32'd5, fifo_words);
        end
        read_words();
        if (read_empty !== 1'b1) begin
            report_value("fifo_read_empty_o", 32'd1, 32'(read_empty));
        end
        end_test("normal mode pre-trigger", err_start);
    endtask

    task automatic stream_overflow();
        int err_start;
        err_start = errors;
        stream_mode = 1'b1;
        downsample  = '0;
        capture_go  = 1'b0;
        arm_capture();
        capture_go = 1'b1;
        drive_samples(SAMPLES_PER_WORD * (FIFO_DEPTH + 2), 0);   // Two words past full
        capture_go = 1'b0;
        pack_kept(2'd0);
        while (exp_q.size() > FIFO_DEPTH) begin
            exp_q.delete(exp_q.size() - 1);        // Late words never stored
        end
        wait_stop();
        if (fifo_overflow !== 1'b1) begin
            report_value("fifo_overflow_o", 32'd1, 32'(fifo_overflow));
        end
        if (fifo_words !== CNT_W'(FIFO_DEPTH)) begin
            report_value("fifo_words_o", 32'(FIFO_DEPTH), fifo_words);
        end
        read_words();
        if (read_empty !== 1'b1) begin
            report_value("fifo_read_empty_o", 32'd1, 32'(read_empty));
        end
        end_test("stream overflow", err_start);
    endtask

    task automatic rearm_clears();
        int err_start;
        err_start = errors;
        if (fifo_overflow !== 1'b1) begin
            report_error("fifo_overflow_o did not hold until the next arm");
        end
        arm_capture();
        if (fifo_overflow !== 1'b0) begin
            report_value("fifo_overflow_o", 32'd0, 32'(fifo_overflow));
        end
        if (capture_stop !== 1'b0) begin
            report_value("capture_stop_o", 32'd0, 32'(capture_stop));
        end
        if (read_empty !== 1'b1) begin
            report_value("fifo_read_empty_o", 32'd1, 32'(read_empty));
        end
        capture_go = 1'b1;                         // Two words, then flush them
        drive_samples(6, 0);
        capture_go = 1'b0;
        wait_words(2);
        arm_capture();
        if (read_empty !== 1'b1) begin
            report_value("fifo_read_empty_o", 32'd1, 32'(read_empty));
        end
        if (fifo_words !== '0) begin
            report_value("fifo_words_o", 32'd0, fifo_words);
        end
        end_test("arm clears", err_start);
    endtask

    initial begin
        seed_init       = $urandom(28);            // Sample values from here on
        fifo_rst        = 1'b1;
        arm             = 1'b0;
        capture_go      = 1'b0;
        stream_mode     = 1'b1;
        adc_data        = '0;
        downsample      = '0;
        presample_words = '0;
        max_samples     = '0;
        read_en         = 1'b0;
        repeat (2) @(posedge adc_sampleclk);
        #5;
        fifo_rst = 1'b0;
        next_cycle();
        after_reset_values();
        stream_capture("stream, downsample 0", 0, 12);
        stream_capture("stream, downsample 2", 2, 18);
        normal_pretrigger();
        stream_overflow();
        rearm_clears();
        $display("Summary: %0d tests, %0d with errors, %0d errors in total",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== src/adc_capture_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module adc_capture_top import capture_pkg::*; #(
    parameter int FIFO_DEPTH = 64
) (
    input  logic                adc_sampleclk,
    input  logic                fifo_rst,
    input  logic                arm_i,               // Rising edge flushes
    input  logic                capture_go_i,        // Trigger level
    input  logic                stream_mode_i,
    input  logic [SAMPLE_W-1:0] adc_data_i,
    input  logic [DS_W-1:0]     downsample_i,
    input  logic [CNT_W-1:0]    presample_words_i,
    input  logic [CNT_W-1:0]    max_samples_i,
    input  logic                read_en_i,           // USB side byte strobe
    output logic                capture_stop_o,
    output logic                fifo_overflow_o,
    output logic                fifo_read_empty_o,
    output logic [7:0]          fifo_read_data_o,
    output logic [CNT_W-1:0]    fifo_words_o
);

    logic              tick;
    logic [WORD_W-1:0] word_data;
    logic              word_valid;
    logic              flush;
    logic              packer_run;
    logic              wr_allow;
    logic              drop;
    logic              read_allow;
    logic              pop;
    logic [WORD_W-1:0] head_word;

    fifo_status_if #(.FIFO_DEPTH(FIFO_DEPTH)) fifo_status ();

    adc_sample_packer u_packer (
        .adc_sampleclk (adc_sampleclk),
        .fifo_rst      (fifo_rst),
        .flush_i       (flush),
        .run_i         (packer_run),
        .capture_go_i  (capture_go_i),
        .adc_data_i    (adc_data_i),
        .downsample_i  (downsample_i),
        .tick_o        (tick),
        .word_data_o   (word_data),
        .word_valid_o  (word_valid)
    );

    capture_control #(.FIFO_DEPTH(FIFO_DEPTH)) u_control (
        .adc_sampleclk     (adc_sampleclk),
        .fifo_rst          (fifo_rst),
        .arm_i             (arm_i),
        .capture_go_i      (capture_go_i),
        .stream_mode_i     (stream_mode_i),
        .tick_i            (tick),
        .word_valid_i      (word_valid),
        .presample_words_i (presample_words_i),
        .max_samples_i     (max_samples_i),
        .status            (fifo_status.ctl),
        .flush_o           (flush),
        .run_o             (packer_run),
        .wr_allow_o        (wr_allow),
        .drop_o            (drop),
        .read_allow_o      (read_allow),
        .capture_stop_o    (capture_stop_o),
        .fifo_overflow_o   (fifo_overflow_o)
    );

    sample_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo (
        .adc_sampleclk (adc_sampleclk),
        .fifo_rst      (fifo_rst),
        .flush_i       (flush),
        .wr_i          (word_valid),
        .wr_allow_i    (wr_allow),
        .wr_data_i     (word_data),
        .pop_i         (pop),
        .drop_i        (drop),
        .head_o        (head_word),
        .status        (fifo_status.src)
    );

    usb_byte_reader u_reader (
        .adc_sampleclk (adc_sampleclk),
        .fifo_rst      (fifo_rst),
        .flush_i       (flush),
        .allow_i       (read_allow),
        .read_en_i     (read_en_i),
        .head_i        (head_word),
        .status        (fifo_status.rd),
        .byte_o        (fifo_read_data_o),
        .pop_o         (pop),
        .empty_o       (fifo_read_empty_o)
    );

    assign fifo_words_o = CNT_W'(fifo_status.word_count);           // Zero extend word count

endmodule

`default_nettype wire

// ==== src/usb_byte_reader.sv ====
`timescale 1ns/1ps
`default_nettype none

module usb_byte_reader import capture_pkg::*; (
    input  logic              adc_sampleclk,
    input  logic              fifo_rst,
    input  logic              flush_i,       // Realign to byte 0
    input  logic              allow_i,       // Read permitted by control
    input  logic              read_en_i,     // Byte read strobe
    input  logic [WORD_W-1:0] head_i,        // FIFO head word
    fifo_status_if.rd         status,
    output logic [7:0]        byte_o,
    output logic              pop_o,         // Head fully read
    output logic              empty_o
);

    localparam int IDX_W = $clog2(BYTES_PER_WORD);

    logic [IDX_W-1:0] byte_idx_q;            // Byte 0 is bits 7:0
    logic             accept;
    logic             last_byte;

    assign accept    = read_en_i && allow_i && !status.empty;
    assign last_byte = (byte_idx_q == IDX_W'(BYTES_PER_WORD - 1));

    always_ff @(posedge adc_sampleclk) begin
        if (fifo_rst || flush_i) begin
            byte_idx_q <= '0;
        end else if (accept) begin
            byte_idx_q <= last_byte ? '0 : byte_idx_q + IDX_W'(1);
        end
    end

    // Combinational byte select off the head word
    assign byte_o  = head_i[{byte_idx_q, 3'b000} +: 8];
    assign pop_o   = accept && last_byte;                           // Advance on fourth byte
    assign empty_o = status.empty;

endmodule

`default_nettype wire

// ==== src/sample_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module sample_fifo import capture_pkg::*; #(
    parameter int FIFO_DEPTH = 64
) (
    input  logic              adc_sampleclk,
    input  logic              fifo_rst,
    input  logic              flush_i,       // Empties the FIFO
    input  logic              wr_i,          // Word strobe from packer
    input  logic              wr_allow_i,    // Write gate from control
    input  logic [WORD_W-1:0] wr_data_i,
    input  logic              pop_i,         // Reader consumed head
    input  logic              drop_i,        // Discard oldest word
    output logic [WORD_W-1:0] head_o,        // First-word fall-through
    fifo_status_if.src        status
);

    localparam int AW       = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_BITS = $clog2(FIFO_DEPTH + 1);

    logic [WORD_W-1:0]   mem [FIFO_DEPTH];
    logic [AW-1:0]       wr_ptr_q;
    logic [AW-1:0]       rd_ptr_q;
    logic [CNT_BITS-1:0] cnt_q;
    logic                ovf_pulse_q;
    logic                is_empty;
    logic                is_full;
    logic                wr_req;
    logic                do_wr;
    logic                do_rd;

    function automatic logic [AW-1:0] ptr_next(input logic [AW-1:0] ptr);
        return (ptr == AW'(FIFO_DEPTH - 1)) ? '0 : ptr + AW'(1);    // Any depth wraps
    endfunction

    assign is_empty = (cnt_q == '0);
    assign is_full  = (cnt_q == CNT_BITS'(FIFO_DEPTH));
    assign wr_req   = wr_i && wr_allow_i;
    assign do_wr    = wr_req && !is_full;                            // Full discards
    assign do_rd    = (pop_i || drop_i) && !is_empty;                // One advance per cycle

    always_ff @(posedge adc_sampleclk) begin
        if (fifo_rst || flush_i) begin
            wr_ptr_q    <= '0;
            rd_ptr_q    <= '0;
            cnt_q       <= '0;
            ovf_pulse_q <= 1'b0;
        end else begin
            ovf_pulse_q <= wr_req && is_full;
            if (do_wr) begin
                wr_ptr_q <= ptr_next(wr_ptr_q);
            end
            if (do_rd) begin
                rd_ptr_q <= ptr_next(rd_ptr_q);
            end
            case ({do_wr, do_rd})
                2'b10:   cnt_q <= cnt_q + CNT_BITS'(1);
                2'b01:   cnt_q <= cnt_q - CNT_BITS'(1);
                default: ;                                           // Both or none keep count
            endcase
        end
    end

    // Storage, no reset
    always_ff @(posedge adc_sampleclk) begin
        if (do_wr) begin
            mem[wr_ptr_q] <= wr_data_i;
        end
    end

    assign head_o                = mem[rd_ptr_q];                   // Valid while not empty
    assign status.word_count     = cnt_q;
    assign status.empty          = is_empty;
    assign status.full           = is_full;
    assign status.overflow_pulse = ovf_pulse_q;

endmodule

`default_nettype wire

// ==== src/capture_control.sv ====
`timescale 1ns/1ps
`default_nettype none

module capture_control import capture_pkg::*; #(
    parameter int FIFO_DEPTH = 64
) (
    input  logic             adc_sampleclk,
    input  logic             fifo_rst,
    input  logic             arm_i,              // Async arm request
    input  logic             capture_go_i,       // Trigger level
    input  logic             stream_mode_i,      // 1 stream, 0 normal
    input  logic             tick_i,             // Kept sample
    input  logic             word_valid_i,       // Word about to be written
    input  logic [CNT_W-1:0] presample_words_i,  // Pre-trigger history in words
    input  logic [CNT_W-1:0] max_samples_i,      // Post-trigger kept samples
    fifo_status_if.ctl       status,
    output logic             flush_o,
    output logic             run_o,
    output logic             wr_allow_o,
    output logic             drop_o,
    output logic             read_allow_o,
    output logic             capture_stop_o,
    output logic             fifo_overflow_o
);

    localparam int CNT_BITS = $clog2(FIFO_DEPTH + 1);

    logic                arm_q1;             // Arm sync stage 1
    logic                arm_q2;             // Arm sync stage 2
    logic                fifo_rst_flush;     // Arm rising edge, one cycle
    logic                trig_seen_q;
    logic                stop_q;
    logic                ovf_q;
    logic [CNT_W-1:0]    post_cnt_q;         // Post-trigger ticks
    logic [CNT_W-1:0]    keep_words;
    logic [CNT_BITS-1:0] words_now;
    logic                trig_active;
    logic                post_done;

    assign words_now   = status.word_count;
    assign keep_words  = (presample_words_i > CNT_W'(FIFO_DEPTH)) ?
                         CNT_W'(FIFO_DEPTH) : presample_words_i;     // Never beyond FIFO size
    assign trig_active = capture_go_i || trig_seen_q;                // Includes trigger cycle
    assign post_done   = trig_seen_q && (post_cnt_q == max_samples_i);

    always_ff @(posedge adc_sampleclk) begin
        if (fifo_rst) begin
            arm_q1         <= 1'b0;
            arm_q2         <= 1'b0;
            fifo_rst_flush <= 1'b0;
        end else begin
            arm_q1         <= arm_i;
            arm_q2         <= arm_q1;
            fifo_rst_flush <= arm_q1 && !arm_q2;                     // Rising edge
        end
    end

    always_ff @(posedge adc_sampleclk) begin
        if (fifo_rst || fifo_rst_flush) begin
            trig_seen_q <= 1'b0;
            stop_q      <= 1'b0;
            ovf_q       <= 1'b0;
            post_cnt_q  <= '0;
        end else begin
            if (capture_go_i) begin
                trig_seen_q <= 1'b1;
            end
            if (!stream_mode_i && tick_i && trig_active && !stop_q &&
                (post_cnt_q != max_samples_i)) begin
                post_cnt_q <= post_cnt_q + CNT_W'(1);                // Saturates at max
            end
            if (status.overflow_pulse) begin
                ovf_q <= 1'b1;                                       // Sticky until arm
            end
            if (stream_mode_i ? status.overflow_pulse : post_done) begin
                stop_q <= 1'b1;
            end
        end
    end

    // Drop oldest word to bound pre-trigger history
    assign drop_o = !stream_mode_i && !trig_seen_q && !stop_q && word_valid_i &&
                    (CNT_W'(words_now) >= keep_words);

    assign flush_o         = fifo_rst_flush;
    assign run_o           = stream_mode_i ? capture_go_i : 1'b1;
    assign wr_allow_o      = !stop_q;
    assign read_allow_o    = stream_mode_i || stop_q;               // Normal mode reads after stop
    assign capture_stop_o  = stop_q;
    assign fifo_overflow_o = ovf_q;

endmodule

`default_nettype wire

// ==== src/adc_sample_packer.sv ====
`timescale 1ns/1ps
`default_nettype none

module adc_sample_packer import capture_pkg::*; (
    input  logic                adc_sampleclk,
    input  logic                fifo_rst,
    input  logic                flush_i,         // Arm flush pulse
    input  logic                run_i,           // Low holds downsample counter at 0
    input  logic                capture_go_i,    // Trigger level
    input  logic [SAMPLE_W-1:0] adc_data_i,
    input  logic [DS_W-1:0]     downsample_i,    // Samples skipped between kept ones
    output logic                tick_o,          // Keep this sample
    output logic [WORD_W-1:0]   word_data_o,
    output logic                word_valid_o     // One cycle after slot 2 fill
);

    logic [DS_W-1:0]     ds_cnt_q;               // Downsample counter
    logic [SLOT_W-1:0]   slot_q;                 // Next slot to fill
    logic [SLOT_W-1:0]   tag_q;                  // Slot at trigger
    logic [SAMPLE_W-1:0] slot0_q;
    logic [SAMPLE_W-1:0] slot1_q;
    logic [SAMPLE_W-1:0] slot2_q;
    logic                word_valid_q;
    logic                last_slot;

    assign tick_o    = run_i && (ds_cnt_q == downsample_i);           // Not decimation, just skip
    assign last_slot = (slot_q == SLOT_W'(SAMPLES_PER_WORD - 1));

    always_ff @(posedge adc_sampleclk) begin
        if (fifo_rst || flush_i || !run_i) begin
            ds_cnt_q <= '0;
        end else if (tick_o) begin
            ds_cnt_q <= '0;                                          // Wrap on tick
        end else begin
            ds_cnt_q <= ds_cnt_q + DS_W'(1);
        end
    end

    // Slot counter, tag and word strobe
    always_ff @(posedge adc_sampleclk) begin
        if (fifo_rst || flush_i) begin
            slot_q       <= '0;
            tag_q        <= SLOT_NONE;
            word_valid_q <= 1'b0;
        end else begin
            word_valid_q <= tick_o && last_slot;                     // Word complete
            if (tick_o) begin
                slot_q <= last_slot ? '0 : slot_q + SLOT_W'(1);
            end
            if (capture_go_i && (tag_q == SLOT_NONE)) begin
                tag_q <= slot_q;                                     // First trigger only
            end
        end
    end

    // Sample registers, payload only
    always_ff @(posedge adc_sampleclk) begin
        if (tick_o) begin
            case (slot_q)
                SLOT_W'(0): slot0_q <= adc_data_i;
                SLOT_W'(1): slot1_q <= adc_data_i;
                SLOT_W'(2): slot2_q <= adc_data_i;
                default:    ;                                        // Unused slot code
            endcase
        end
    end

    always_comb begin
        word_data_o                            = '0;
        word_data_o[TAG_LSB   +: SLOT_W]       = tag_q;
        word_data_o[SLOT2_LSB +: SAMPLE_W]     = slot2_q;
        word_data_o[SLOT1_LSB +: SAMPLE_W]     = slot1_q;
        word_data_o[SLOT0_LSB +: SAMPLE_W]     = slot0_q;
    end

    assign word_valid_o = word_valid_q;

endmodule

`default_nettype wire

// ==== src/fifo_status_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface fifo_status_if #(
    parameter int FIFO_DEPTH = 64
);

    localparam int CNT_BITS = $clog2(FIFO_DEPTH + 1);    // Holds 0..FIFO_DEPTH

    logic [CNT_BITS-1:0] word_count;                      // Stored words
    logic                empty;                           // No word stored
    logic                full;                            // FIFO_DEPTH words stored
    logic                overflow_pulse;                  // Write hit a full FIFO

    modport src (
        output word_count, empty, full, overflow_pulse
    );

    modport ctl (
        input  word_count, overflow_pulse
    );

    modport rd (
        input  empty
    );

endinterface

`default_nettype wire

// ==== src/capture_pkg.sv ====
`default_nettype none

package capture_pkg;

    // Sample and word geometry
    localparam int SAMPLE_W         = 10;      // One ADC sample
    localparam int WORD_W           = 32;      // Packed FIFO word
    localparam int SAMPLES_PER_WORD = 3;       // Samples packed per word
    localparam int BYTES_PER_WORD   = 4;       // Bytes per word on the USB side

    // Trigger slot tag
    localparam int SLOT_W = 2;                                // Tag and slot counter width
    localparam logic [SLOT_W-1:0] SLOT_NONE = SLOT_W'(3);     // No trigger seen yet

    // Control widths
    localparam int DS_W  = 13;                 // Downsample setting
    localparam int CNT_W = 32;                 // Sample and word counters

    // Word layout, LSB positions of each field
    localparam int TAG_LSB   = 30;             // Bits 31:30
    localparam int SLOT2_LSB = 20;             // Bits 29:20
    localparam int SLOT1_LSB = 10;             // Bits 19:10
    localparam int SLOT0_LSB = 0;              // Bits 9:0

endpackage

`default_nettype wire
